// ==== fpAddPkg.sv ====
// Shared format constants, opcode enum and stage structs; imported by every pipeline stage
`default_nettype none

package fpAddPkg;

    localparam int expWidth = 8;                                 // IEEE-754 single exponent field
    localparam int manWidth = 23;                                // Stored fraction, implicit one excluded
    localparam int expBias  = 127;                               // Exponent bias of the format

    typedef enum logic
    {
        opAdd = 1'b0,                                            // A + B
        opSub = 1'b1                                             // A - B
    } fpOp_t;

    // Operands split into fields, first pipeline register
    typedef struct packed
    {
        logic                valid;
        logic                signA;
        logic                signB;
        logic [expWidth-1:0] exponentA;
        logic [expWidth-1:0] exponentB;
        logic [manWidth-1:0] mantissaA;                          // Fraction only
        logic [manWidth-1:0] mantissaB;
        logic                subtract;                           // Effective subtraction
    } fpUnpacked_t;

    typedef struct packed
    {
        logic                valid;
        logic                signA;
        logic                subtract;
        logic [expWidth-1:0] exponentOut;                        // Larger of the two exponents
        logic [manWidth:0]   alignedMantissaA;                   // Implicit one included
        logic [manWidth:0]   alignedMantissaB;
        logic                guardBit;                           // Tail of the shifted operand
        logic                roundBit;
        logic                stickyBit;
    } fpAligned_t;

    typedef struct packed
    {
        logic                valid;
        logic                sign;                               // Final sign of the result
        logic [expWidth-1:0] exponent;
        logic [manWidth+1:0] sumMantissa;                        // MSB is the carry out
        logic                guardBit;
        logic                roundBit;
        logic                stickyBit;
        logic                isZero;                             // Exact cancellation
    } fpSum_t;

endpackage

`default_nettype wire

// ==== fpUnpack.sv ====
// Input stage of the FP adder; takes operands under valid/ready and registers their fields
`timescale 1ns/100ps
`default_nettype none

module fpUnpack
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,                       // Global pipeline enable
    input  logic                  inValid,
    input  logic [31:0]           inA,
    input  logic [31:0]           inB,
    input  fpAddPkg::fpOp_t       inOp,
    output fpAddPkg::fpUnpacked_t stageOut
);

    import fpAddPkg::*;

    fpUnpacked_t nextStage;                                      // Combinational field split

    always_comb
    begin
        nextStage.valid     = inValid;                           // Transfer happens whenever advance is high
        nextStage.signA     = inA[31];
        nextStage.signB     = inB[31];
        nextStage.exponentA = inA[manWidth+expWidth-1:manWidth];
        nextStage.exponentB = inB[manWidth+expWidth-1:manWidth];
        nextStage.mantissaA = inA[manWidth-1:0];
        nextStage.mantissaB = inB[manWidth-1:0];
        // Signs differ for add, or agree for subtract
        nextStage.subtract  = inA[31] ^ inB[31] ^ (inOp == opSub);
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            stageOut <= nextStage;                               // Fields carry no reset
        end
        if (rst)
        begin
            stageOut.valid <= 1'b0;                              // Only valid is control state
        end
    end

endmodule

`default_nettype wire

// ==== fpAlign.sv ====
// Second adder stage; compares exponents and shifts the smaller mantissa with guard/round/sticky
`timescale 1ns/100ps
`default_nettype none

module fpAlign
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  fpAddPkg::fpUnpacked_t stageIn,
    output fpAddPkg::fpAligned_t  stageOut
);

    import fpAddPkg::*;

    logic [manWidth+2:0] extA, extB;                             // Implicit one plus two tail zeros
    logic [manWidth+2:0] extSmall;                               // Operand with the smaller exponent
    logic [manWidth+2:0] shifted;                                // {aligned, guard, round}
    logic [expWidth-1:0] expDiff;                                // Exponent differential
    logic                aLarger;                                // A keeps its position
    logic                sticky;
    fpAligned_t          nextStage;

    always_comb
    begin
        extA     = {1'b1, stageIn.mantissaA, 2'b00};
        extB     = {1'b1, stageIn.mantissaB, 2'b00};
        aLarger  = stageIn.exponentA >= stageIn.exponentB;       // Equal exponents shift B by zero
        expDiff  = aLarger ? stageIn.exponentA - stageIn.exponentB
                           : stageIn.exponentB - stageIn.exponentA;
        extSmall = aLarger ? extB : extA;
        shifted  = extSmall >> expDiff;                          // Zero once expDiff passes 26
        if (expDiff > 8'd26)
            sticky = |extSmall;                                  // Everything falls past round
        else
            sticky = |(extSmall << (8'd26 - expDiff));           // Only bits shifted out below round

        nextStage.valid            = stageIn.valid;
        nextStage.signA            = stageIn.signA;
        nextStage.subtract         = stageIn.subtract;
        nextStage.exponentOut      = aLarger ? stageIn.exponentA : stageIn.exponentB;
        nextStage.alignedMantissaA = aLarger ? extA[manWidth+2:2] : shifted[manWidth+2:2];
        nextStage.alignedMantissaB = aLarger ? shifted[manWidth+2:2] : extB[manWidth+2:2];
        nextStage.guardBit         = shifted[1];
        nextStage.roundBit         = shifted[0];
        nextStage.stickyBit        = sticky;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            stageOut <= nextStage;
        end
        if (rst)
        begin
            stageOut.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fpMantissaAdd.sv ====
// Third adder stage; adds or subtracts the aligned magnitudes and picks the result sign
`timescale 1ns/100ps
`default_nettype none

module fpMantissaAdd
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  fpAddPkg::fpAligned_t stageIn,
    output fpAddPkg::fpSum_t     stageOut
);

    import fpAddPkg::*;

    logic                aLarger;                                // Magnitude of A is not below B
    logic                signB;                                  // Effective sign of B
    logic [manWidth+4:0] bigExt;                                 // {carry, mantissa, 3 zero tail bits}
    logic [manWidth+4:0] smallExt;                               // {carry, mantissa, guard, round, sticky}
    logic [manWidth+4:0] rawSum;
    fpSum_t              nextStage;

    always_comb
    begin
        // A nonzero tail only exists on the shifted operand, which is then strictly smaller
        aLarger  = stageIn.alignedMantissaA >= stageIn.alignedMantissaB;
        signB    = stageIn.signA ^ stageIn.subtract;
        bigExt   = aLarger ? {1'b0, stageIn.alignedMantissaA, 3'b000}
                           : {1'b0, stageIn.alignedMantissaB, 3'b000};
        smallExt = aLarger ? {1'b0, stageIn.alignedMantissaB, stageIn.guardBit,
                              stageIn.roundBit, stageIn.stickyBit}
                           : {1'b0, stageIn.alignedMantissaA, stageIn.guardBit,
                              stageIn.roundBit, stageIn.stickyBit};
        rawSum   = stageIn.subtract ? bigExt - smallExt : bigExt + smallExt;  // Tail borrows included

        nextStage.valid       = stageIn.valid;
        nextStage.sign        = (stageIn.subtract && !aLarger) ? signB : stageIn.signA;
        nextStage.exponent    = stageIn.exponentOut;
        nextStage.sumMantissa = rawSum[manWidth+4:3];
        nextStage.guardBit    = rawSum[2];
        nextStage.roundBit    = rawSum[1];
        nextStage.stickyBit   = rawSum[0];
        nextStage.isZero      = stageIn.subtract && (rawSum == '0);      // Exact cancellation
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            stageOut <= nextStage;
        end
        if (rst)
        begin
            stageOut.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fpNormalizeRound.sv ====
// Fourth adder stage; normalizes the raw sum, rounds to nearest even and packs the result word
`timescale 1ns/100ps
`default_nettype none

module fpNormalizeRound
(
    input  logic             clk,
    input  logic             rst,
    input  logic             advance,
    input  fpAddPkg::fpSum_t stageIn,
    output logic             resultValid,
    output logic [31:0]      result
);

    import fpAddPkg::*;

    logic                carry;                                  // Sum overflowed into bit 24
    logic [4:0]          lzCount;                                // Leading zeros of the 24-bit sum
    logic [manWidth+3:0] shiftedSum;                             // {mantissa, guard, round, sticky}
    logic [manWidth:0]   normMantissa;
    logic                guard, round, sticky;
    logic [expWidth-1:0] expNorm;
    logic                roundUp;
    logic [manWidth+1:0] rounded;                                // MSB flags a rounding carry
    logic [expWidth-1:0] expFinal;
    logic [31:0]         packed_;

    always_comb
    begin
        carry   = stageIn.sumMantissa[manWidth+1];
        lzCount = 5'd24;                                         // Only reached on cancellation
        for (int i = 0; i <= manWidth; i++)
        begin
            if (stageIn.sumMantissa[i])
                lzCount = 5'(manWidth - i);                      // Highest set bit wins
        end
        // Left shift is only large when the tail is exact, so zero fill is safe
        shiftedSum = {stageIn.sumMantissa[manWidth:0], stageIn.guardBit,
                      stageIn.roundBit, stageIn.stickyBit} << lzCount;

        if (carry)
        begin
            normMantissa = stageIn.sumMantissa[manWidth+1:1];    // One place right
            guard        = stageIn.sumMantissa[0];
            round        = stageIn.guardBit;
            sticky       = stageIn.roundBit | stageIn.stickyBit; // Merge the old tail
            expNorm      = stageIn.exponent + 8'd1;
        end
        else
        begin
            normMantissa = shiftedSum[manWidth+3:3];
            guard        = shiftedSum[2];
            round        = shiftedSum[1];
            sticky       = shiftedSum[0];
            expNorm      = stageIn.exponent - 8'(lzCount);
        end

        roundUp  = guard & (round | sticky | normMantissa[0]);   // Nearest, ties to even
        rounded  = {1'b0, normMantissa} + (manWidth+2)'(roundUp);
        // A rounding carry leaves a zero fraction, so only the exponent moves
        expFinal = expNorm + 8'(rounded[manWidth+1]);
        packed_  = stageIn.isZero ? 32'h0000_0000
                                  : {stageIn.sign, expFinal, rounded[manWidth-1:0]};
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            result <= packed_;                                   // Payload, no reset
        end
        if (rst)
            resultValid <= 1'b0;
        else if (advance)
            resultValid <= stageIn.valid;
    end

endmodule

`default_nettype wire

// ==== fpAddOut.sv ====
// Output register of the FP adder; holds a result under valid/ready and drives pipeline advance
`timescale 1ns/100ps
`default_nettype none

module fpAddOut
(
    input  logic        clk,
    input  logic        rst,
    input  logic        resultValid,
    input  logic [31:0] result,
    input  logic        outReady,
    output logic        outValid,
    output logic [31:0] outResult,
    output logic        advance
);

    // Free slot or consumer taking the current word, so everything may move
    assign advance = !outValid || outReady;

    always_ff @(posedge clk)
    begin
        if (rst)
            outValid <= 1'b0;
        else if (advance)
            outValid <= resultValid;                             // Bubbles clear the slot
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            outResult <= result;                                 // Held stable while stalled
        end
    end

endmodule

`default_nettype wire

// ==== fpAddTop.sv ====
// Top level of the pipelined single-precision adder/subtractor; connects the five stages
`timescale 1ns/100ps
`default_nettype none

module fpAddTop
(
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    output logic            inReady,
    input  logic [31:0]     inA,
    input  logic [31:0]     inB,
    input  fpAddPkg::fpOp_t inOp,
    output logic            outValid,
    input  logic            outReady,
    output logic [31:0]     outResult
);

    import fpAddPkg::*;

    fpUnpacked_t unpacked;                                       // Stage 1 register
    fpAligned_t  aligned;                                        // Stage 2 register
    fpSum_t      summed;                                         // Stage 3 register
    logic        resultValid;                                    // Stage 4 register
    logic [31:0] result;
    logic        advance;                                        // Moves all stages together

    assign inReady = advance;

    fpUnpack uUnpack (.clk, .rst, .advance, .inValid, .inA, .inB, .inOp, .stageOut(unpacked));

    fpAlign uAlign (.clk, .rst, .advance, .stageIn(unpacked), .stageOut(aligned));

    fpMantissaAdd uMantissaAdd (.clk, .rst, .advance, .stageIn(aligned), .stageOut(summed));

    fpNormalizeRound uNormalizeRound
    (
        .clk,
        .rst,
        .advance,
        .stageIn(summed),
        .resultValid,
        .result
    );

    fpAddOut uOut (.clk, .rst, .resultValid, .result, .outReady, .outValid, .outResult, .advance);

endmodule

`default_nettype wire

// ==== fpAddBind_sva.sv ====
// Handshake and reset assertions for the FP adder, bound into the top level for simulation
`timescale 1ns/100ps
`default_nettype none

module fpAddSva
(
    input logic        clk,
    input logic        rst,
    input logic        inReady,
    input logic        outValid,
    input logic        outReady,
    input logic [31:0] outResult
);

    // Output slot is empty once reset has been seen
    resetClearsOutput: assert property (@(posedge clk) rst |=> !outValid)
        else $error("outValid high in the cycle after reset");

    // A stalled result stays put until the consumer takes it
    stallHoldsOutput: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outResult)))
        else $error("Stalled output changed before it was taken");

    // Input side may only take data when the whole pipeline moves
    readyFollowsAdvance: assert property (@(posedge clk) inReady == (!outValid || outReady))
        else $error("inReady differs from the pipeline advance condition");

endmodule

bind fpAddTop fpAddSva sva0 (.clk, .rst, .inReady, .outValid, .outReady, .outResult);

`default_nettype wire

// ==== fpAddTb.sv ====
// Self-checking testbench for the FP adder; random operands checked against a real-number model
`timescale 1ns/100ps
`default_nettype none

module fpAddTb;

    import fpAddPkg::*;

    localparam int burstCount = 16;                              // Back-to-back, no stalls
    localparam int totalCount = 2000;
    localparam int waitLimit  = 1000;                            // Cycles allowed per wait loop

    logic        clk = 1'b0;
    logic        rst;
    logic        inValid;
    logic        inReady;
    logic [31:0] inA;
    logic [31:0] inB;
    fpOp_t       inOp;
    logic        outValid;
    logic        outReady;
    logic [31:0] outResult;

    integer      seed;
    logic        stallEnable;                                    // Random outReady when set
    logic [31:0] expectedQueue[$];                               // Model results in input order
    logic [31:0] expectedWord;
    int          edgeCount, acceptCount, outCount;               // Updated with NBAs, read race free
    int          firstAcceptEdge, firstOutEdge, lastOutEdge;

    fpAddTop dut0 (.clk, .rst, .inValid, .inReady, .inA, .inB, .inOp, .outValid, .outReady,
                   .outResult);

    always #10 clk = ~clk;                                       // 20 ns period

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
            abortRun($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    endtask

    function automatic real toReal(input logic [31:0] x);
        logic [10:0] expDouble;
        expDouble = {3'b000, x[30:23]} + 11'd896;                // Rebias 127 to 1023
        return $bitstoreal({x[31], expDouble, x[22:0], 29'd0});
    endfunction

    // Reference: exact double sum, then round to nearest even at 23 fraction bits
    function automatic logic [31:0] modelResult(input logic [31:0] a, input logic [31:0] b,
                                                input fpOp_t op);
        logic [31:0] bEff;
        int          expA;
        int          expB;
        real         sum;
        logic [63:0] bits;
        logic [23:0] keep;
        logic [10:0] expOut;
        bEff = (op == opSub) ? {~b[31], b[30:0]} : b;            // Subtract flips the sign of B
        expA = int'(a[30:23]);
        expB = int'(bEff[30:23]);
        if (expA - expB > 28)
            return a;                                            // Smaller one is below half an ulp
        if (expB - expA > 28)
            return bEff;
        sum = toReal(a) + toReal(bEff);                          // Exact, at most 53 bits wide
        if (sum == 0.0)
            return 32'h0000_0000;                                // Cancellation gives +0
        bits = $realtobits(sum);
        keep = {1'b0, bits[51:29]};
        if (bits[28] && ((|bits[27:0]) || keep[0]))
            keep = keep + 24'd1;
        expOut = bits[62:52] - 11'd896 + {10'd0, keep[23]};      // Rounding carry bumps exponent
        return {bits[63], expOut[7:0], keep[22:0]};
    endfunction

    task automatic stepClock();
        @(posedge clk);
        if (stallEnable)
            outReady <= ({$random(seed)} % 10) >= 3;             // Low about 30% of cycles
        else
            outReady <= 1'b1;
    endtask

    // Four operand shapes: wide add, near cancellation, exact negatives, halfway ties
    task automatic makeOperands(output logic [31:0] a, output logic [31:0] b, output fpOp_t op);
        int          category;
        int          expA;
        int          diff;
        logic        signA;
        logic        signB;
        logic [22:0] fracA;
        logic [23:0] sigB;
        logic [23:0] tailMask;
        logic [31:0] swapWord;
        category = {$random(seed)} % 4;
        expA     = 70 + {$random(seed)} % 150;                   // Minus 40 still stays above 29
        signA    = 1'($random(seed));
        fracA    = 23'($random(seed));
        sigB     = {1'b1, 23'($random(seed))};
        a        = {signA, 8'(expA), fracA};
        case (category)
            0:
            begin
                diff = {$random(seed)} % 41;                     // Includes shifts past sticky
                b    = {signA, 8'(expA - diff), sigB[22:0]};
                op   = opAdd;
            end
            1:
            begin
                diff     = {$random(seed)} % 3;
                tailMask = (24'd1 << ({$random(seed)} % 23 + 1)) - 24'd1;
                sigB     = {1'b1, fracA ^ (23'($random(seed)) & tailMask[22:0])};
                op       = 1'($random(seed)) ? opSub : opAdd;
                signB    = (op == opSub) ? signA : ~signA;       // Effective subtraction either way
                b        = {signB, 8'(expA - diff), sigB[22:0]};
            end
            2:
            begin
                op = 1'($random(seed)) ? opSub : opAdd;
                b  = (op == opSub) ? a : {~a[31], a[30:0]};
            end
            default:
            begin
                diff     = 1 + {$random(seed)} % 23;
                tailMask = (24'd1 << diff) - 24'd1;
                sigB     = (sigB & ~tailMask) | (24'd1 << (diff - 1));  // Shifted-out bits 100..0
                signB    = 1'($random(seed));
                op       = 1'($random(seed)) ? opSub : opAdd;
                b        = {signB, 8'(expA - diff), sigB[22:0]};
            end
        endcase
        if (1'($random(seed)))
        begin
            swapWord = a;
            a        = b;
            b        = swapWord;
        end
    endtask

    task automatic sendOperands(input logic [31:0] a, input logic [31:0] b, input fpOp_t op);
        int   waited;
        logic taken;
        inA     <= a;
        inB     <= b;
        inOp    <= op;
        inValid <= 1'b1;
        waited  = 0;
        taken   = 1'b0;
        while (!taken)
        begin
            stepClock();
            taken = inReady;                                     // Value seen by the DUT at this edge
            waited++;
            if (!taken && waited >= waitLimit)
                abortRun("Timeout: the adder never accepted an operand pair");
        end
    endtask

    task automatic waitResults(input int count);
        int waited;
        waited = 0;
        while (outCount < count)
        begin
            stepClock();
            waited++;
            if (waited >= waitLimit)
                abortRun("Timeout: expected results did not come out of the adder");
        end
    endtask

    // Scoreboard, pushes on input transfers and pops on output transfers
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (inValid && inReady)
            begin
                expectedQueue.push_back(modelResult(inA, inB, inOp));
                if (acceptCount == 0)
                    firstAcceptEdge <= edgeCount;
                acceptCount <= acceptCount + 1;
            end
            if (outValid && outReady)
            begin
                if (expectedQueue.size() == 0)
                    abortRun("Output transfer without any pending input");
                else
                begin
                    expectedWord = expectedQueue.pop_front();
                    checkValue("outResult", outResult, expectedWord);
                    if (outCount == 0)
                        firstOutEdge <= edgeCount;
                    lastOutEdge <= edgeCount;
                    outCount    <= outCount + 1;
                end
            end
            edgeCount <= edgeCount + 1;
        end
    end

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        fpOp_t       op;
        seed        = 20085;
        rst         = 1'b1;
        inValid     = 1'b0;
        inA         = 32'd0;
        inB         = 32'd0;
        inOp        = opAdd;
        outReady    = 1'b1;
        stallEnable = 1'b0;
        edgeCount   = 0;
        acceptCount = 0;
        outCount    = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < burstCount; i++)
        begin
            makeOperands(a, b, op);
            sendOperands(a, b, op);
        end
        inValid <= 1'b0;
        waitResults(burstCount);
        // Four stage registers plus the output slot, then one result per cycle
        checkValue("first result latency", 32'(firstOutEdge - firstAcceptEdge), 32'd5);
        checkValue("burst result spacing", 32'(lastOutEdge - firstOutEdge), 32'(burstCount - 1));

        stallEnable = 1'b1;
        for (int i = burstCount; i < totalCount; i++)
        begin
            makeOperands(a, b, op);
            if ({$random(seed)} % 5 == 0)
            begin
                inValid <= 1'b0;                                 // Bubble on the input side
                stepClock();
            end
            sendOperands(a, b, op);
        end
        inValid <= 1'b0;
        waitResults(totalCount);

        if (expectedQueue.size() != 0 || acceptCount != totalCount)
            abortRun("Scoreboard not empty or wrong number of accepted inputs at the end");
        else
        begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
fpAddPkg.sv
fpUnpack.sv
fpAlign.sv
fpMantissaAdd.sv
fpNormalizeRound.sv
fpAddOut.sv
fpAddTop.sv
fpAddBind_sva.sv
fpAddTb.sv

// ==== Makefile ====
# Verilator build and run of the FP adder testbench
VERILATOR ?= verilator
TOP       ?= fpAddTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
